// ==== verilog.f ====
hw/dcache_pkg.sv
hw/dcache_line_ram.sv
hw/dcache_ctrl.sv
hw/dcache_stats.sv
hw/dcache_top.sv
tb/bus_memory.sv
tb/dcache_assert.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the data cache simulation with Verilator.
set -e

verilator --binary --timing --assert -Wno-fatal \
	--top-module dcache_tb -f verilog.f -o dcache_sim

./obj_dir/dcache_sim 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
	echo "Simulation did not complete"
	exit 1
fi

echo "Simulation passed"

// ==== tb/dcache_tb.sv ====
//======================================================================
// Testbench of the data cache. Random and directed accesses, checked
// against a shadow model of the lines and of the bus memory.
//======================================================================
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	localparam int N_RANDOM = 300;
	localparam int TOTAL_ACCESSES = N_RANDOM + 40;
	localparam int WATCHDOG_CYCLES = TOTAL_ACCESSES * 40 + 4 * (LINES + 1 + 4);

	logic i_clock, i_reset, i_request, i_rw, i_flush, i_cacheable;
	logic [ADDR_W-1:0] i_address, bus_address;
	logic [DATA_W-1:0] i_wdata, o_rdata, bus_wdata, bus_rdata;
	logic o_ready, bus_request, bus_rw, bus_ready;
	logic [COUNT_W-1:0] o_hit_count, o_miss_count;

	// Shadow state of the cache lines and of the memory.
	logic [31:0] ref_mem [1024];
	logic [31:0] line_data [LINES];
	logic [31:0] line_addr [LINES];
	logic line_valid [LINES];
	logic line_dirty [LINES];
	logic [COUNT_W-1:0] exp_hits, exp_misses;
	logic [31:0] exp_rdata;
	logic exp_check_read, ready_seen;
	int error_count;

	dcache_top uut (
		.i_clock(i_clock), .i_reset(i_reset), .i_request(i_request), .i_rw(i_rw),
		.i_flush(i_flush), .i_cacheable(i_cacheable), .i_address(i_address),
		.i_wdata(i_wdata), .o_ready(o_ready), .o_rdata(o_rdata),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw), .o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata), .i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata),
		.o_hit_count(o_hit_count), .o_miss_count(o_miss_count)
	);

	bus_memory mem (
		.i_clock(i_clock), .i_reset(i_reset), .i_request(bus_request), .i_rw(bus_rw),
		.i_address(bus_address), .i_wdata(bus_wdata), .o_ready(bus_ready),
		.o_rdata(bus_rdata)
	);

	bind dcache_ctrl dcache_assert protocol_check (
		.i_clock(i_clock), .i_reset(i_reset), .i_state(state), .i_ready(o_ready),
		.i_bus_request(o_bus_request), .i_bus_rw(o_bus_rw),
		.i_bus_address(o_bus_address), .i_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			error_count++;
			$display("FAILED time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
		end
	endtask

	// Write a line back to the shadow memory if it holds dirty data.
	function automatic void write_back(input int idx);
		if (line_valid[idx] && line_dirty[idx]) begin
			ref_mem[line_addr[idx][11:2]] = line_data[idx];
			line_dirty[idx] = 1'b0;
		end
	endfunction

	// Reference model. Updates the shadow state, returns the read data.
	function automatic logic [31:0] predict(input logic rw, input logic cacheable,
			input logic flush, input logic [31:0] addr, input logic [31:0] wdata);
		int idx;
		logic hit;
		idx = int'(addr[7:2]);
		if (flush) begin
			for (int l = 0; l < LINES; l++)
				write_back(l);
			return 32'h0;
		end
		if (!cacheable) begin
			if (rw)
				ref_mem[addr[11:2]] = wdata;
			return rw ? 32'h0 : ref_mem[addr[11:2]];
		end
		hit = line_valid[idx] && (line_addr[idx][31:2] == addr[31:2]);
		if (hit)
			exp_hits = exp_hits + 1;
		else
			exp_misses = exp_misses + 1;
		if (!hit) begin
			write_back(idx);
			line_data[idx] = ref_mem[addr[11:2]];
			line_dirty[idx] = 1'b0;
		end
		line_valid[idx] = 1'b1;
		line_addr[idx] = {addr[31:2], 2'b00};
		if (rw) begin
			line_data[idx] = wdata;
			line_dirty[idx] = 1'b1;
		end
		return line_data[idx];
	endfunction

	function automatic void clear_shadow();
		for (int l = 0; l < LINES; l++) begin
			line_valid[l] = 1'b0;
			line_dirty[l] = 1'b0;
		end
		exp_hits = '0;
		exp_misses = '0;
	endfunction

	// One CPU access from request to the cycle after ready.
	task automatic do_access(input logic rw, input logic cacheable, input logic flush,
			input logic [31:0] addr, input logic [31:0] wdata);
		exp_rdata = predict(rw, cacheable, flush, addr, wdata);
		exp_check_read = !rw && !flush;
		i_request <= 1'b1;
		i_rw <= rw;
		i_cacheable <= cacheable;
		i_flush <= flush;
		i_address <= addr;
		i_wdata <= wdata;
		do @(posedge i_clock); while (o_ready !== 1'b1);
		i_request <= 1'b0;
		@(posedge i_clock);
		@(posedge i_clock);
	endtask

	task automatic apply_reset();
		i_reset <= 1'b1;
		repeat (4) @(posedge i_clock);
		i_reset <= 1'b0;
		clear_shadow();
		@(posedge i_clock);
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 1024; i++)
			check_value("bus memory word", ref_mem[i], mem.mem[i]);
	endtask

	// Compare process runs one cycle after each ready pulse.
	always @(posedge i_clock) begin
		if (ready_seen) begin
			if (exp_check_read)
				check_value("o_rdata", exp_rdata, o_rdata);
			check_value("o_hit_count", exp_hits, o_hit_count);
			check_value("o_miss_count", exp_misses, o_miss_count);
		end
		ready_seen <= (o_ready === 1'b1) && !i_reset;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("Watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	initial begin
		logic [31:0] rnd, addr;
		int writes_before;
		void'($urandom(32'h0ca633db));
		error_count = 0;
		ready_seen = 1'b0;
		exp_check_read = 1'b0;
		exp_rdata = '0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_flush = 1'b0;
		i_cacheable = 1'b0;
		i_address = '0;
		i_wdata = '0;
		clear_shadow();
		repeat (4) @(posedge i_clock);
		for (int i = 0; i < 1024; i++)
			ref_mem[i] = mem.mem[i];
		i_reset <= 1'b0;
		@(posedge i_clock);

		// Random mix over four tags on eight lines.
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $urandom;
			addr = {22'd0, rnd[9:8], 3'd0, rnd[2:0], 2'b00};
			do_access(rnd[16], rnd[19:17] != 3'd0, 1'b0, addr, $urandom);
		end

		// Flush, then a second flush that must stay off the bus.
		do_access(1'b0, 1'b1, 1'b1, 32'h0, 32'h0);
		compare_memory();
		writes_before = mem.write_count;
		do_access(1'b0, 1'b1, 1'b1, 32'h0, 32'h0);
		check_value("bus write count", writes_before, mem.write_count);

		// Eviction of a dirty line by a colliding write.
		do_access(1'b1, 1'b1, 1'b0, 32'h050, 32'hcafe0050);
		do_access(1'b1, 1'b1, 1'b0, 32'h150, 32'hbeef0150);
		check_value("evicted word", 32'hcafe0050, mem.mem[20]);

		// Uncached accesses, then a cached copy that differs from memory.
		do_access(1'b1, 1'b0, 1'b0, 32'h060, 32'h12340060);
		check_value("uncached word", 32'h12340060, mem.mem[24]);
		do_access(1'b0, 1'b0, 1'b0, 32'h060, 32'h0);
		do_access(1'b1, 1'b1, 1'b0, 32'h064, 32'haaaa0064);
		do_access(1'b1, 1'b0, 1'b0, 32'h064, 32'h55550064);
		do_access(1'b0, 1'b1, 1'b0, 32'h064, 32'h0);
		do_access(1'b0, 1'b0, 1'b0, 32'h064, 32'h0);

		// Reset in mid-run drops the lines and the counts.
		for (int i = 0; i < 8; i++)
			do_access(1'b1, 1'b1, 1'b0, i * 4, $urandom);
		apply_reset();
		check_value("o_hit_count", 32'h0, o_hit_count);
		check_value("o_miss_count", 32'h0, o_miss_count);
		for (int i = 0; i < 8; i++)
			do_access(1'b0, 1'b1, 1'b0, i * 4, 32'h0);
		check_value("o_miss_count", 32'd8, o_miss_count);

		do_access(1'b0, 1'b1, 1'b1, 32'h0, 32'h0);
		compare_memory();

		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/dcache_assert.sv ====
//======================================================================
// Bus and ready protocol checks, bound to the cache controller.
//======================================================================
`timescale 1ns/100ps
`default_nettype none

module dcache_assert
	import dcache_pkg::*;
(
	input logic              i_clock,
	input logic              i_reset,
	input ctrl_state_t       i_state,
	input logic              i_ready,
	input logic              i_bus_request,
	input logic              i_bus_rw,
	input logic [ADDR_W-1:0] i_bus_address,
	input logic [DATA_W-1:0] i_bus_wdata,
	input logic              i_bus_ready
);

	// A pending transfer holds its fields until the memory answers.
	property bus_request_held;
		@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=>
			(i_bus_request && $stable(i_bus_rw) && $stable(i_bus_address) &&
			$stable(i_bus_wdata));
	endproperty

	property ready_single_pulse;
		@(posedge i_clock) disable iff (i_reset)
		i_ready |=> !i_ready;
	endproperty

	property no_bus_during_init;
		@(posedge i_clock) disable iff (i_reset)
		(i_state == INITIALIZE) |-> !i_bus_request;
	endproperty

	assert property (bus_request_held) else $error("bus request changed before ready");
	assert property (ready_single_pulse) else $error("o_ready high for two cycles");
	assert property (no_bus_during_init) else $error("bus request during initialize");

endmodule

`default_nettype wire

// ==== tb/bus_memory.sv ====
//======================================================================
// Behavioral memory on the cache bus side. Answers each transfer after
// zero to three random extra cycles with a one-cycle ready pulse.
//======================================================================
`timescale 1ns/100ps
`default_nettype none

module bus_memory (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata
);

	// Word array, indexed by address bits 11 to 2.
	logic [31:0] mem [1024];
	logic        busy;
	logic [1:0]  wait_left;
	logic [31:0] rnd;
	int          write_count;

	// Fill pattern built from the whole word address.
	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = (i * 32'h9e3779b1) ^ 32'h5a5a0000 ^ i;
		end
		write_count = 0;
	end

	always @(posedge i_clock) begin
		o_ready <= 1'b0;
		if (i_reset) begin
			busy <= 1'b0;
		end
		else if (i_request && !o_ready) begin
			if (!busy) begin
				busy <= 1'b1;
				rnd = $urandom;
				wait_left <= rnd[1:0];
			end
			else if (wait_left == 2'd0) begin
				busy <= 1'b0;
				o_ready <= 1'b1;
				if (i_rw) begin
					mem[i_address[11:2]] <= i_wdata;
					write_count <= write_count + 1;
				end
				else begin
					o_rdata <= mem[i_address[11:2]];
				end
			end
			else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
//====================================================================
// Top level of the data cache. Sits between a CPU load/store port
// and a memory bus, with hit and miss counts on the side.
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  logic               i_clock,
	input  logic               i_reset,

	// CPU side.
	input  logic               i_request,
	input  logic               i_rw,
	input  logic               i_flush,
	input  logic               i_cacheable,
	input  logic [ADDR_W-1:0]  i_address,
	input  logic [DATA_W-1:0]  i_wdata,
	output logic               o_ready,
	output logic [DATA_W-1:0]  o_rdata,

	// Bus side.
	output logic               o_bus_request,
	output logic               o_bus_rw,
	output logic [ADDR_W-1:0]  o_bus_address,
	output logic [DATA_W-1:0]  o_bus_wdata,
	input  logic               i_bus_ready,
	input  logic [DATA_W-1:0]  i_bus_rdata,

	// Statistics.
	output logic [COUNT_W-1:0] o_hit_count,
	output logic [COUNT_W-1:0] o_miss_count
);

	logic ram_rw;
	logic [LINE_BITS-1:0] ram_address;
	logic [ENTRY_W-1:0] ram_wdata;
	logic [ENTRY_W-1:0] ram_rdata;
	logic hit_event;
	logic miss_event;

	dcache_ctrl ctrl (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_flush       (i_flush),
		.i_cacheable   (i_cacheable),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.o_ram_rw      (ram_rw),
		.o_ram_address (ram_address),
		.o_ram_wdata   (ram_wdata),
		.i_ram_rdata   (ram_rdata),
		.o_hit_event   (hit_event),
		.o_miss_event  (miss_event)
	);

	dcache_line_ram line_ram (
		.i_clock   (i_clock),
		.i_rw      (ram_rw),
		.i_address (ram_address),
		.i_wdata   (ram_wdata),
		.o_rdata   (ram_rdata)
	);

	dcache_stats stats (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_hit_event  (hit_event),
		.i_miss_event (miss_event),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

endmodule

`default_nettype wire

// ==== hw/dcache_stats.sv ====
//====================================================================
// Hit and miss counters of the data cache, fed by one-cycle event
// pulses from the controller.
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module dcache_stats
	import dcache_pkg::*;
(
	input  logic               i_clock,
	input  logic               i_reset,
	input  logic               i_hit_event,
	input  logic               i_miss_event,
	output logic [COUNT_W-1:0] o_hit_count,
	output logic [COUNT_W-1:0] o_miss_count
);

	// Both counters stop at all ones.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit_count <= '0;
			o_miss_count <= '0;
		end
		else begin
			if (i_hit_event && (o_hit_count != '1))
				o_hit_count <= o_hit_count + 1'b1;

			if (i_miss_event && (o_miss_count != '1))
				o_miss_count <= o_miss_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
//====================================================================
// Data cache controller. Handles lookup, fill, write-back, flush,
// the initialize sweep and uncached pass-through to the bus.
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic                 i_clock,
	input  logic                 i_reset,

	// CPU side.
	input  logic                 i_request,
	input  logic                 i_rw,
	input  logic                 i_flush,
	input  logic                 i_cacheable,
	input  logic [ADDR_W-1:0]    i_address,
	input  logic [DATA_W-1:0]    i_wdata,
	output logic                 o_ready,
	output logic [DATA_W-1:0]    o_rdata,

	// Bus side.
	output logic                 o_bus_request,
	output logic                 o_bus_rw,
	output logic [ADDR_W-1:0]    o_bus_address,
	output logic [DATA_W-1:0]    o_bus_wdata,
	input  logic                 i_bus_ready,
	input  logic [DATA_W-1:0]    i_bus_rdata,

	// Line store.
	output logic                 o_ram_rw,
	output logic [LINE_BITS-1:0] o_ram_address,
	output logic [ENTRY_W-1:0]   o_ram_wdata,
	input  logic [ENTRY_W-1:0]   i_ram_rdata,

	// Statistics.
	output logic                 o_hit_event,
	output logic                 o_miss_event
);

	ctrl_state_t state;

	// Sweep counter for initialize and flush, one bit wider than the index.
	logic [LINE_BITS:0] sweep;

	// Pending line store write, issued one cycle after the decision.
	logic ram_rw_q;
	logic [ENTRY_W-1:0] ram_wdata_q;

	// Fields of the entry read back from the line store.
	logic entry_valid;
	logic entry_dirty;
	logic entry_match;
	logic [ADDR_W-1:0] entry_address;
	logic [DATA_W-1:0] entry_data;
	logic [ADDR_W-1:0] req_address;

	assign entry_valid = i_ram_rdata[0];
	assign entry_dirty = i_ram_rdata[1];
	assign entry_address = {i_ram_rdata[ADDR_W-1:2], 2'b00};
	assign entry_data = i_ram_rdata[ENTRY_W-1:ADDR_W];
	assign req_address = {i_address[ADDR_W-1:2], 2'b00};
	assign entry_match = entry_valid && (i_ram_rdata[ADDR_W-1:2] == i_address[ADDR_W-1:2]);

	// Sweep states walk the lines, everything else uses the request index.
	always_comb begin
		case (state)
			INITIALIZE, FLUSH_SETUP, FLUSH_CHECK, FLUSH_WRITE, FLUSH_NEXT:
				o_ram_address = sweep[LINE_BITS-1:0];
			default:
				o_ram_address = i_address[LINE_BITS+1:2];
		endcase
	end

	// The sweep clears one line per cycle until the top bit of the counter sets.
	always_comb begin
		if (state == INITIALIZE) begin
			o_ram_rw = !sweep[LINE_BITS];
			o_ram_wdata = '0;
		end
		else begin
			o_ram_rw = ram_rw_q;
			o_ram_wdata = ram_wdata_q;
		end
	end

	// Raise a bus transfer with its fields.
	task automatic start_bus(
		input logic              rw,
		input logic [ADDR_W-1:0] address,
		input logic [DATA_W-1:0] wdata
	);
		o_bus_request <= 1'b1;
		o_bus_rw <= rw;
		o_bus_address <= address;
		o_bus_wdata <= wdata;
	endtask

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			sweep <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			o_hit_event <= 1'b0;
			o_miss_event <= 1'b0;
			ram_rw_q <= 1'b0;
		end
		else begin
			o_ready <= 1'b0;
			o_hit_event <= 1'b0;
			o_miss_event <= 1'b0;
			ram_rw_q <= 1'b0;

			case (state)
				// Hot line check straight from the last read entry.
				IDLE: begin
					if (i_request && !o_ready) begin
						if (i_flush) begin
							sweep <= '0;
							state <= FLUSH_SETUP;
						end
						else if (!i_cacheable) begin
							start_bus(i_rw, i_address, i_wdata);
							state <= PASS_THROUGH;
						end
						else if (entry_match) begin
							o_hit_event <= 1'b1;
							o_ready <= 1'b1;
							if (i_rw) begin
								ram_rw_q <= 1'b1;
								ram_wdata_q <= {i_wdata, i_address[ADDR_W-1:2], 2'b11};
							end
							else begin
								o_rdata <= entry_data;
							end
						end
						else if (i_rw) begin
							state <= WRITE_SETUP;
						end
						else begin
							state <= READ_SETUP;
						end
					end
				end

				//====================================================================
				// Flush
				//====================================================================
				FLUSH_SETUP: begin
					if (!sweep[LINE_BITS]) begin
						state <= FLUSH_CHECK;
					end
					else begin
						sweep <= '0;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				FLUSH_CHECK: begin
					if (entry_dirty) begin
						start_bus(1'b1, entry_address, entry_data);
						state <= FLUSH_WRITE;
					end
					else begin
						sweep <= sweep + 1'b1;
						state <= FLUSH_SETUP;
					end
				end

				// Line goes back clean once the bus takes it.
				FLUSH_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						ram_rw_q <= 1'b1;
						ram_wdata_q <= {entry_data, entry_address[ADDR_W-1:2], 2'b01};
						state <= FLUSH_NEXT;
					end
				end

				FLUSH_NEXT: begin
					sweep <= sweep + 1'b1;
					state <= FLUSH_SETUP;
				end

				// Uncached access.
				PASS_THROUGH: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						if (!o_bus_rw)
							o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				//====================================================================
				// Write
				//====================================================================
				WRITE_SETUP: begin
					o_hit_event <= entry_match;
					o_miss_event <= !entry_match;
					if (entry_dirty && !entry_match) begin
						start_bus(1'b1, entry_address, entry_data);
						state <= WRITE_WAIT;
					end
					else begin
						ram_rw_q <= 1'b1;
						ram_wdata_q <= {i_wdata, i_address[ADDR_W-1:2], 2'b11};
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// Victim is out, store the new word.
				WRITE_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						ram_rw_q <= 1'b1;
						ram_wdata_q <= {i_wdata, i_address[ADDR_W-1:2], 2'b11};
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				//====================================================================
				// Read
				//====================================================================
				READ_SETUP: begin
					o_hit_event <= entry_match;
					o_miss_event <= !entry_match;
					if (entry_match) begin
						o_rdata <= entry_data;
						o_ready <= 1'b1;
						state <= IDLE;
					end
					else if (entry_dirty) begin
						start_bus(1'b1, entry_address, entry_data);
						state <= READ_WB_WAIT;
					end
					else begin
						start_bus(1'b0, req_address, o_bus_wdata);
						state <= READ_BUS_WAIT;
					end
				end

				READ_WB_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= READ_BUS_WAIT;
					end
				end

				// After a write-back the fill request starts one cycle later.
				READ_BUS_WAIT: begin
					if (!o_bus_request) begin
						start_bus(1'b0, req_address, o_bus_wdata);
					end
					else if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						ram_rw_q <= 1'b1;
						ram_wdata_q <= {i_bus_rdata, i_address[ADDR_W-1:2], 2'b01};
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				INITIALIZE: begin
					if (!sweep[LINE_BITS]) begin
						sweep <= sweep + 1'b1;
					end
					else begin
						sweep <= '0;
						state <= IDLE;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/dcache_line_ram.sv ====
//====================================================================
// Line store of the data cache. Single port, always enabled, with
// read data one cycle after the address.
//====================================================================
`timescale 1ns/100ps
`default_nettype none

module dcache_line_ram
	import dcache_pkg::*;
(
	input  logic                 i_clock,
	input  logic                 i_rw,
	input  logic [LINE_BITS-1:0] i_address,
	input  logic [ENTRY_W-1:0]   i_wdata,
	output logic [ENTRY_W-1:0]   o_rdata
);

	// One entry per line.
	logic [ENTRY_W-1:0] mem [LINES];

	//====================================================================
	// Registered read, synchronous write
	//====================================================================

	// Write-first. A line written at this edge reads back the new
	// entry, so the controller never sees a stale copy of the line
	// it just updated.
	always_ff @(posedge i_clock) begin
		if (i_rw) begin
			mem[i_address] <= i_wdata;
			o_rdata <= i_wdata;
		end
		else begin
			o_rdata <= mem[i_address];
		end
	end

endmodule

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
//====================================================================
// Shared geometry and controller states for the direct-mapped data
// cache. Modules take it with a wildcard import in their header.
//====================================================================
`default_nettype none

package dcache_pkg;

	// Bus and word widths.
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Line index is address bits 7 to 2.
	localparam int LINE_BITS = 6;
	localparam int LINES = 1 << LINE_BITS;

	// Entry layout, from the top bit down.
	//   [63:32] data word
	//   [31:2]  address bits 31 to 2
	//   [1]     dirty
	//   [0]     valid
	localparam int ENTRY_W = DATA_W + ADDR_W;

	// Width of each statistics counter.
	localparam int COUNT_W = 32;

	typedef enum logic [3:0] {
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		FLUSH_NEXT,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT,
		INITIALIZE
	} ctrl_state_t;

endpackage

`default_nettype wire
